// File: rtl/otp_part_defines.svh
////////////////////////////////////////
// OTP partition sizing
// Block width, partition geometry and
// address widths shared by the design
////////////////////////////////////////

`ifndef OTP_PART_DEFINES_SVH
`define OTP_PART_DEFINES_SVH

// One buffered block, as returned by the macro
`define OTP_BLK_W        64

// Blocks in the partition, the last one holds the digest
`define PART_NUM_BLKS    4

// Byte offset of the partition inside OTP
`define PART_OFFSET      11'h040

// Macro works on halfword addresses
`define OTP_ADDR_W       10
`define OTP_ADDR_SHIFT   1
`define OTP_BYTE_ADDR_W  11

// Block counter width
`define PART_CNT_W       2

`endif

// File: rtl/otp_macro_pkg.sv
////////////////////////////////////////
// OTP macro interface types
// Request and response structs of the
// req/gnt/rvalid port and error codes
////////////////////////////////////////

`include "otp_part_defines.svh"

package otp_macro_pkg;

  ////////////////////////////////////////
  // Error codes returned with rvalid
  ////////////////////////////////////////

  typedef enum logic [2:0] {
    MacroOk             = 3'd0,
    MacroError          = 3'd1,
    // Single bit flip, data already corrected
    MacroEccCorrError   = 3'd2,
    // Data cannot be trusted
    MacroEccUncorrError = 3'd3
  } macro_err_e;

  ////////////////////////////////////////
  // Port structs
  ////////////////////////////////////////

  // Held with a stable address until gnt
  typedef struct packed {
    logic                   req;
    logic [`OTP_ADDR_W-1:0] addr;
  } otp_req_t;

  // One rvalid per granted request
  typedef struct packed {
    logic                  gnt;
    logic                  rvalid;
    logic [`OTP_BLK_W-1:0] rdata;
    macro_err_e            err;
  } otp_rsp_t;

endpackage

// File: rtl/otp_part_pkg.sv
////////////////////////////////////////
// OTP partition types
// Controller states, partition error
// codes and the lock struct
////////////////////////////////////////

package otp_part_pkg;

  ////////////////////////////////////////
  // Partition error codes
  ////////////////////////////////////////

  // Lower codes line up with the macro codes
  typedef enum logic [2:0] {
    NoError             = 3'd0,
    MacroError          = 3'd1,
    MacroEccCorrError   = 3'd2,
    MacroEccUncorrError = 3'd3,
    // Readback differs from the buffer
    CheckFailError      = 3'd4,
    // Escalation, counter fault or illegal state
    FsmStateError       = 3'd5
  } part_err_e;

  ////////////////////////////////////////
  // Controller states
  ////////////////////////////////////////

  typedef enum logic [2:0] {
    ResetSt         = 3'd0,
    InitSt          = 3'd1,
    InitWaitSt      = 3'd2,
    IdleSt          = 3'd3,
    CnstyReadSt     = 3'd4,
    CnstyReadWaitSt = 3'd5,
    // Terminal, only left through reset
    ErrorSt         = 3'd6
  } part_state_e;

  // Lock bits, 1 means locked
  typedef struct packed {
    logic read_lock;
    logic write_lock;
  } part_access_t;

endpackage

// File: rtl/otp_part_fsm.sv
////////////////////////////////////////
// OTP partition controller FSM
// Sequences the init readout and the
// consistency readback, latches errors
// and owns the partition lock
////////////////////////////////////////

`timescale 1ns/1ps

module otp_part_fsm (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    init_req_i,
  input  logic                    integ_chk_req_i,
  input  logic                    cnsty_chk_req_i,
  input  logic                    escalate_en_i,
  input  logic                    check_byp_en_i,
  output logic                    otp_req_valid_o,
  input  otp_macro_pkg::otp_rsp_t otp_rsp_i,
  input  logic                    cnt_last_i,
  input  logic                    cnt_err_i,
  input  logic                    blk_match_i,
  output logic                    cnt_clr_o,
  output logic                    cnt_en_o,
  output logic                    buf_wr_en_o,
  output logic                    locked_o,
  output logic                    integ_chk_ack_o,
  output logic                    cnsty_chk_ack_o,
  output logic                    fsm_err_o,
  output otp_part_pkg::part_err_e error_o
);

  import otp_part_pkg::*;

  part_state_e state_d, state_q;
  part_err_e   error_d, error_q;
  part_err_e   rsp_err;
  logic        locked_d, locked_q;
  logic        rsp_ok;

  // Macro codes map one to one onto partition codes
  assign rsp_err = part_err_e'(otp_rsp_i.err);
  // Corrected data is still usable
  assign rsp_ok  = (rsp_err == NoError) || (rsp_err == MacroEccCorrError);

  always_comb begin
    state_d         = state_q;
    error_d         = error_q;
    locked_d        = locked_q;
    otp_req_valid_o = 1'b0;
    cnt_clr_o       = 1'b0;
    cnt_en_o        = 1'b0;
    buf_wr_en_o     = 1'b0;
    integ_chk_ack_o = 1'b0;
    cnsty_chk_ack_o = 1'b0;
    fsm_err_o       = 1'b0;

    unique case (state_q)
      // Wait for the one init request after reset
      ResetSt: begin
        if (init_req_i) begin
          state_d   = InitSt;
          cnt_clr_o = 1'b1;
        end
      end
      // Request block at the counter address
      InitSt: begin
        otp_req_valid_o = 1'b1;
        if (otp_rsp_i.gnt) begin
          state_d = InitWaitSt;
        end
      end
      // Capture the block, then next block or unlock
      InitWaitSt: begin
        if (otp_rsp_i.rvalid) begin
          buf_wr_en_o = 1'b1;
          if (rsp_ok) begin
            if (cnt_last_i) begin
              state_d  = IdleSt;
              locked_d = 1'b0;
            end else begin
              state_d  = InitSt;
              cnt_en_o = 1'b1;
            end
            if (rsp_err != NoError) begin
              error_d = MacroEccCorrError;
            end
          end else begin
            state_d = ErrorSt;
            error_d = rsp_err;
          end
        end
      end
      // No hardware digest here, integrity is acked at once
      IdleSt: begin
        if (integ_chk_req_i) begin
          integ_chk_ack_o = 1'b1;
        end
        if (cnsty_chk_req_i) begin
          state_d   = CnstyReadSt;
          cnt_clr_o = 1'b1;
        end
      end
      // Re-read block for comparison
      CnstyReadSt: begin
        otp_req_valid_o = 1'b1;
        if (otp_rsp_i.gnt) begin
          state_d = CnstyReadWaitSt;
        end
      end
      // Compare against the buffer, bypass excuses a mismatch
      CnstyReadWaitSt: begin
        if (otp_rsp_i.rvalid) begin
          if (!rsp_ok) begin
            state_d         = ErrorSt;
            error_d         = rsp_err;
            cnsty_chk_ack_o = 1'b1;
          end else if (blk_match_i || check_byp_en_i) begin
            if (cnt_last_i) begin
              state_d         = IdleSt;
              cnsty_chk_ack_o = 1'b1;
            end else begin
              state_d  = CnstyReadSt;
              cnt_en_o = 1'b1;
            end
            if (rsp_err != NoError) begin
              error_d = MacroEccCorrError;
            end
          end else begin
            state_d         = ErrorSt;
            error_d         = CheckFailError;
            cnsty_chk_ack_o = 1'b1;
          end
        end
      end
      // Terminal, relock and answer every request
      ErrorSt: begin
        locked_d        = 1'b1;
        integ_chk_ack_o = 1'b1;
        cnsty_chk_ack_o = 1'b1;
      end
      // Illegal encoding
      default: begin
        state_d   = ErrorSt;
        fsm_err_o = 1'b1;
        if (error_q == NoError) begin
          error_d = FsmStateError;
        end
      end
    endcase

    ////////////////////////////////////////
    // Fatal events override everything
    ////////////////////////////////////////

    // A corrected ECC code is not fatal, so it gets replaced
    if (escalate_en_i || cnt_err_i) begin
      state_d   = ErrorSt;
      fsm_err_o = 1'b1;
      if ((error_q == NoError) || (error_q == MacroEccCorrError)) begin
        error_d = FsmStateError;
      end
    end
  end

  // Partition starts locked
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= ResetSt;
      error_q  <= NoError;
      locked_q <= 1'b1;
    end else begin
      state_q  <= state_d;
      error_q  <= error_d;
      locked_q <= locked_d;
    end
  end

  assign locked_o = locked_q;
  assign error_o  = error_q;

endmodule

// File: rtl/otp_part_cnt.sv
////////////////////////////////////////
// Redundant block counter
// Counter plus inverted shadow copy,
// last-block flag and OTP address
////////////////////////////////////////

`timescale 1ns/1ps

`include "otp_part_defines.svh"

module otp_part_cnt (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   clr_i,
  input  logic                   en_i,
  output logic [`PART_CNT_W-1:0] blk_idx_o,
  output logic                   last_o,
  output logic                   err_o,
  output logic [`OTP_ADDR_W-1:0] addr_o
);

  localparam int unsigned LastBlk = `PART_NUM_BLKS - 1;

  logic [`PART_CNT_W-1:0]      cnt_q, cnt_n_q;
  logic [`OTP_BYTE_ADDR_W-1:0] blk_ofs, byte_addr;

  // Shadow holds the bitwise inverse, decremented in step
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q   <= '0;
      cnt_n_q <= '1;
    end else if (clr_i) begin
      cnt_q   <= '0;
      cnt_n_q <= '1;
    end else if (en_i) begin
      cnt_q   <= cnt_q + 1'b1;
      cnt_n_q <= cnt_n_q - 1'b1;
    end
  end

  // Any disagreement is a fault
  assign err_o     = (cnt_q != ~cnt_n_q);
  assign last_o    = (cnt_q == LastBlk[`PART_CNT_W-1:0]);
  assign blk_idx_o = cnt_q;

  // Eight bytes per block, then byte to halfword
  assign blk_ofs   = {{(`OTP_BYTE_ADDR_W - `PART_CNT_W - 3){1'b0}}, cnt_q, 3'b000};
  assign byte_addr = `PART_OFFSET + blk_ofs;
  assign addr_o    = byte_addr[`OTP_BYTE_ADDR_W-1:`OTP_ADDR_SHIFT];

endmodule

// File: rtl/otp_part_buf_regs.sv
////////////////////////////////////////
// Partition buffer registers
// Block storage, readback compare,
// output gating and lock aggregation
////////////////////////////////////////

`timescale 1ns/1ps

`include "otp_part_defines.svh"

module otp_part_buf_regs (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  input  logic                                   wr_en_i,
  input  logic [`PART_CNT_W-1:0]                 blk_idx_i,
  input  logic [`OTP_BLK_W-1:0]                  rdata_i,
  input  logic                                   locked_i,
  input  otp_part_pkg::part_access_t             access_i,
  output logic                                   blk_match_o,
  output otp_part_pkg::part_access_t             access_o,
  output logic [`OTP_BLK_W-1:0]                  digest_o,
  output logic [`PART_NUM_BLKS*`OTP_BLK_W-1:0]   data_o
);

  import otp_part_pkg::*;

  logic [`PART_NUM_BLKS-1:0][`OTP_BLK_W-1:0] blk_q;
  part_access_t                              access_q;
  logic                                      digest_set;

  ////////////////////////////////////////
  // Block storage
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (wr_en_i) begin
      blk_q[blk_idx_i] <= rdata_i;
    end
  end

  // Readback against the buffered copy
  assign blk_match_o = (blk_q[blk_idx_i] == rdata_i);

  // Data only visible once unlocked
  assign data_o   = locked_i ? '0 : blk_q;
  // Digest is never gated
  assign digest_o = blk_q[`PART_NUM_BLKS-1];

  ////////////////////////////////////////
  // Lock aggregation
  ////////////////////////////////////////

  // Nonzero digest means the partition is finalized
  assign digest_set = (digest_o != '0);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      access_q <= '{read_lock: 1'b1, write_lock: 1'b1};
    end else begin
      access_q.read_lock  <= locked_i | access_i.read_lock;
      access_q.write_lock <= locked_i | access_i.write_lock | digest_set;
    end
  end

  assign access_o = access_q;

endmodule

// File: rtl/otp_part_buf.sv
////////////////////////////////////////
// Buffered OTP partition
// Reads the partition into registers,
// exposes it once unlocked and runs
// consistency readback checks
////////////////////////////////////////

`timescale 1ns/1ps

`include "otp_part_defines.svh"

module otp_part_buf (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic                                 init_req_i,
  output logic                                 init_done_o,
  input  logic                                 integ_chk_req_i,
  output logic                                 integ_chk_ack_o,
  input  logic                                 cnsty_chk_req_i,
  output logic                                 cnsty_chk_ack_o,
  input  logic                                 escalate_en_i,
  input  logic                                 check_byp_en_i,
  output otp_part_pkg::part_err_e              error_o,
  output logic                                 fsm_err_o,
  input  otp_part_pkg::part_access_t           access_i,
  output otp_part_pkg::part_access_t           access_o,
  output logic [`OTP_BLK_W-1:0]                digest_o,
  output logic [`PART_NUM_BLKS*`OTP_BLK_W-1:0] data_o,
  output otp_macro_pkg::otp_req_t              otp_req_o,
  input  otp_macro_pkg::otp_rsp_t              otp_rsp_i
);

  logic                   otp_req_valid;
  logic [`OTP_ADDR_W-1:0] otp_addr;
  logic                   cnt_clr, cnt_en, cnt_last, cnt_err;
  logic [`PART_CNT_W-1:0] blk_idx;
  logic                   buf_wr_en, locked, blk_match;

  otp_part_fsm u_fsm (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .init_req_i      (init_req_i),
    .integ_chk_req_i (integ_chk_req_i),
    .cnsty_chk_req_i (cnsty_chk_req_i),
    .escalate_en_i   (escalate_en_i),
    .check_byp_en_i  (check_byp_en_i),
    .otp_req_valid_o (otp_req_valid),
    .otp_rsp_i       (otp_rsp_i),
    .cnt_last_i      (cnt_last),
    .cnt_err_i       (cnt_err),
    .blk_match_i     (blk_match),
    .cnt_clr_o       (cnt_clr),
    .cnt_en_o        (cnt_en),
    .buf_wr_en_o     (buf_wr_en),
    .locked_o        (locked),
    .integ_chk_ack_o (integ_chk_ack_o),
    .cnsty_chk_ack_o (cnsty_chk_ack_o),
    .fsm_err_o       (fsm_err_o),
    .error_o         (error_o)
  );

  otp_part_cnt u_cnt (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .clr_i     (cnt_clr),
    .en_i      (cnt_en),
    .blk_idx_o (blk_idx),
    .last_o    (cnt_last),
    .err_o     (cnt_err),
    .addr_o    (otp_addr)
  );

  otp_part_buf_regs u_buf_regs (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .wr_en_i     (buf_wr_en),
    .blk_idx_i   (blk_idx),
    .rdata_i     (otp_rsp_i.rdata),
    .locked_i    (locked),
    .access_i    (access_i),
    .blk_match_o (blk_match),
    .access_o    (access_o),
    .digest_o    (digest_o),
    .data_o      (data_o)
  );

  // Macro request from FSM valid and counter address
  assign otp_req_o.req  = otp_req_valid;
  assign otp_req_o.addr = otp_addr;

  // Unlocked means initialized
  assign init_done_o = ~locked;

endmodule

// File: sim/otp_part_assert.sv
////////////////////////////////////////
// OTP partition assertions
// Lock, escalation and handshake rules
// bound onto the partition top level
////////////////////////////////////////

`timescale 1ns/1ps

`include "otp_part_defines.svh"

module otp_part_assert (
  input logic                       clk_i,
  input logic                       rst_ni,
  input logic                       init_done_o,
  input logic                       escalate_en_i,
  input otp_part_pkg::part_access_t access_i,
  input otp_part_pkg::part_access_t access_o,
  input otp_part_pkg::part_err_e    error_o,
  input otp_macro_pkg::otp_req_t    otp_req_o,
  input otp_macro_pkg::otp_rsp_t    otp_rsp_i
);

  import otp_part_pkg::*;

  // access_o lags one cycle, so look once it has caught up
  locked_before_init: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (!init_done_o ##1 !init_done_o) |-> (access_o.read_lock && access_o.write_lock))
    else $error("partition unlocked while init_done_o is low");

  runtime_lock_prop: assert property (@(posedge clk_i) disable iff (!rst_ni)
    access_i.read_lock |=> access_o.read_lock)
    else $error("runtime read lock not propagated");

  runtime_wlock_prop: assert property (@(posedge clk_i) disable iff (!rst_ni)
    access_i.write_lock |=> access_o.write_lock)
    else $error("runtime write lock not propagated");

  escalation_err: assert property (@(posedge clk_i) disable iff (!rst_ni)
    escalate_en_i |=> (error_o != NoError))
    else $error("escalation left error_o at NoError");

  // Escalation may drop a pending request
  addr_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (otp_req_o.req && !otp_rsp_i.gnt && !escalate_en_i)
      |=> (otp_req_o.req && $stable(otp_req_o.addr)))
    else $error("OTP request changed before grant");

endmodule

bind otp_part_buf otp_part_assert u_assert (.*);

// File: sim/tb_otp_part.sv
////////////////////////////////////////
// OTP partition testbench
// Macro model, scenarios, reference
// model and output checker
////////////////////////////////////////

`timescale 1ns/1ps

`include "otp_part_defines.svh"

module tb_otp_part;

  import otp_part_pkg::*;

  localparam int unsigned DataW = `PART_NUM_BLKS * `OTP_BLK_W;
  localparam int unsigned WdogNs = 6 * 200 * 40;

  typedef struct packed {
    logic [DataW-1:0]      data;
    logic [`OTP_BLK_W-1:0] digest;
    part_access_t          access;
    part_err_e             error;
    logic                  done;
  } exp_t;

  logic clk_i, rst_ni, init_req_i, integ_chk_req_i, cnsty_chk_req_i;
  logic escalate_en_i, check_byp_en_i;
  logic init_done_o, integ_chk_ack_o, cnsty_chk_ack_o, fsm_err_o;
  part_access_t             access_i, access_o;
  part_err_e                error_o;
  logic [`OTP_BLK_W-1:0]    digest_o;
  logic [DataW-1:0]         data_o;
  otp_macro_pkg::otp_req_t  otp_req_o;
  otp_macro_pkg::otp_rsp_t  otp_rsp_i;

  // Model memory, image at init time, and scenario state
  logic [`OTP_BLK_W-1:0]    mem [`PART_NUM_BLKS];
  logic [`OTP_BLK_W-1:0]    init_mem [`PART_NUM_BLKS];
  otp_macro_pkg::macro_err_e inj_code;
  int   inj_blk, err_cnt, rd_idx, gnt_dly, rsp_dly, rsp_blk;
  logic pend, loaded, chk_fail, escal, chk_en, ok;
  integer seed;

  otp_part_buf u_otp_part_buf (.*);

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  initial begin
    #(WdogNs);
    $display("Watchdog expired before the tests finished");
    $display("*** FAILED ***");
    $finish;
  end

  ////////////////////////////////////////
  // OTP macro model
  ////////////////////////////////////////

  initial begin
    otp_rsp_i = '0;
    pend = 1'b0;
    rd_idx = 0;
    gnt_dly = 0;
    forever begin
      @(posedge clk_i);
      #2;
      otp_rsp_i.gnt    = 1'b0;
      otp_rsp_i.rvalid = 1'b0;
      otp_rsp_i.err    = otp_macro_pkg::MacroOk;
      if (!rst_ni) begin
        pend   = 1'b0;
        rd_idx = 0;
      end else if (pend) begin
        if (rsp_dly == 0) begin
          otp_rsp_i.rvalid = 1'b1;
          otp_rsp_i.rdata  = mem[rsp_blk];
          if (rsp_blk == inj_blk) otp_rsp_i.err = inj_code;
          pend = 1'b0;
        end else begin
          rsp_dly--;
        end
      end else if (otp_req_o.req) begin
        if (gnt_dly == 0) begin
          // Blocks are 8 bytes apart, halfword addressed from 0x20
          if (otp_req_o.addr != 10'(32'h20 + rd_idx * 4)) begin
            err_cnt++;
            $display("** Error at %0t: otp_req_o.addr expected %h got %h", $time,
                     10'(32'h20 + rd_idx * 4), otp_req_o.addr);
          end
          otp_rsp_i.gnt = 1'b1;
          rsp_blk = rd_idx;
          rd_idx  = (rd_idx + 1) % `PART_NUM_BLKS;
          pend    = 1'b1;
          rsp_dly = (int'($random(seed)) & 3) % 3;
          gnt_dly = int'($random(seed)) & 3;
        end else begin
          gnt_dly--;
        end
      end
    end
  end

  ////////////////////////////////////////
  // Reference model and checker
  ////////////////////////////////////////

  function automatic exp_t ref_outputs(input logic ld, input part_access_t acc,
                                       input otp_macro_pkg::macro_err_e inj,
                                       input logic cfail, input logic esc);
    exp_t e;
    logic unlocked;
    if (inj == otp_macro_pkg::MacroEccUncorrError || inj == otp_macro_pkg::MacroError)
      e.error = part_err_e'(inj);
    else if (cfail) e.error = CheckFailError;
    else if (esc) e.error = FsmStateError;
    else if (inj == otp_macro_pkg::MacroEccCorrError) e.error = MacroEccCorrError;
    else e.error = NoError;
    unlocked = ld && (e.error == NoError || e.error == MacroEccCorrError);
    e.done   = unlocked;
    e.digest = init_mem[`PART_NUM_BLKS-1];
    e.data   = '0;
    for (int i = 0; i < `PART_NUM_BLKS; i++) begin
      if (unlocked) e.data[i*`OTP_BLK_W +: `OTP_BLK_W] = init_mem[i];
    end
    e.access.read_lock  = !unlocked || acc.read_lock;
    e.access.write_lock = !unlocked || acc.write_lock || (e.digest != '0);
    return e;
  endfunction

  task automatic report(input string name, input logic [DataW-1:0] exp_v,
                        input logic [DataW-1:0] act_v);
    err_cnt++;
    $display("** Error at %0t: %s expected %h got %h", $time, name, exp_v, act_v);
  endtask

  always @(negedge clk_i) begin
    exp_t e;
    if (chk_en) begin
      e = ref_outputs(loaded, access_i, inj_code, chk_fail, escal);
      if (data_o !== e.data) report("data_o", e.data, data_o);
      if (loaded && digest_o !== e.digest)
        report("digest_o", DataW'(e.digest), DataW'(digest_o));
      if (access_o !== e.access) report("access_o", DataW'(e.access), DataW'(access_o));
      if (error_o !== e.error) report("error_o", DataW'(e.error), DataW'(error_o));
      if (init_done_o !== e.done)
        report("init_done_o", DataW'(e.done), DataW'(init_done_o));
    end
  end

  ////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////

  task automatic step();
    @(posedge clk_i);
    #2;
  endtask

  task automatic fill_mem(input logic zero_digest);
    for (int i = 0; i < `PART_NUM_BLKS; i++) begin
      mem[i] = {$random(seed), $random(seed)};
      if (i == `PART_NUM_BLKS - 1) mem[i] = zero_digest ? '0 : (mem[i] | 64'h1);
      init_mem[i] = mem[i];
    end
  endtask

  task automatic reset_dut();
    chk_en = 0;
    rst_ni = 0;
    {init_req_i, integ_chk_req_i, cnsty_chk_req_i, escalate_en_i, check_byp_en_i} = '0;
    access_i = '0;
    inj_code = otp_macro_pkg::MacroOk;
    inj_blk  = -1;
    {loaded, chk_fail, escal} = '0;
    repeat (3) step();
    rst_ni = 1;
  endtask

  // Let registered outputs settle, then compare for n cycles
  task automatic check_for(input int n);
    chk_en = 0;
    repeat (2) step();
    chk_en = 1;
    repeat (n) step();
    chk_en = 0;
  endtask

  task automatic run_init(input logic expect_done);
    step();
    init_req_i = 1;
    step();
    init_req_i = 0;
    ok = 0;
    for (int n = 0; n < 80 && !ok; n++) begin
      @(negedge clk_i);
      ok = init_done_o;
    end
    step();
    if (ok != expect_done) begin
      err_cnt++;
      $display("Init completion was %0d but %0d was expected", ok, expect_done);
    end
    loaded = ok;
  endtask

  task automatic run_cnsty();
    step();
    cnsty_chk_req_i = 1;
    step();
    cnsty_chk_req_i = 0;
    ok = 0;
    for (int n = 0; n < 80 && !ok; n++) begin
      @(negedge clk_i);
      ok = cnsty_chk_ack_o;
    end
    step();
    if (!ok) begin
      err_cnt++;
      $display("Consistency check was never acknowledged");
    end
  endtask

  // Integrity and consistency requests answered in the same cycle
  task automatic check_same_cycle_acks(input logic both);
    integ_chk_req_i = 1;
    cnsty_chk_req_i = both;
    @(negedge clk_i);
    if (!integ_chk_ack_o) begin
      err_cnt++;
      $display("Integrity request was not acknowledged in the same cycle");
    end
    if (both && !cnsty_chk_ack_o) begin
      err_cnt++;
      $display("Consistency request in the error state was not acknowledged at once");
    end
    step();
    integ_chk_req_i = 0;
    cnsty_chk_req_i = 0;
  endtask

  ////////////////////////////////////////
  // Scenarios
  ////////////////////////////////////////

  initial begin
    seed = 32'he356_1385;
    err_cnt = 0;
    reset_dut();
    // Init readout and runtime locks
    fill_mem(1'b0);
    reset_dut();
    check_for(3);
    run_init(1'b1);
    check_for(3);
    access_i = '{read_lock: 1'b1, write_lock: 1'b0};
    check_for(3);
    // Zero digest lets write_lock follow access_i
    fill_mem(1'b1);
    reset_dut();
    run_init(1'b1);
    check_for(3);
    access_i = '{read_lock: 1'b0, write_lock: 1'b1};
    check_for(3);
    access_i = '0;
    check_for(3);
    // Consistency check, clean and then corrupted
    fill_mem(1'b0);
    reset_dut();
    run_init(1'b1);
    run_cnsty();
    check_for(3);
    mem[1] = mem[1] ^ 64'h10;
    run_cnsty();
    chk_fail = 1;
    check_for(3);
    check_same_cycle_acks(1'b1);
    // Bypass excuses the same mismatch
    fill_mem(1'b0);
    reset_dut();
    run_init(1'b1);
    mem[1] = mem[1] ^ 64'h10;
    check_byp_en_i = 1;
    run_cnsty();
    check_for(3);
    // Correctable then uncorrectable macro errors
    fill_mem(1'b0);
    reset_dut();
    inj_blk  = 2;
    inj_code = otp_macro_pkg::MacroEccCorrError;
    run_init(1'b1);
    check_for(3);
    reset_dut();
    inj_blk  = 1;
    inj_code = otp_macro_pkg::MacroEccUncorrError;
    run_init(1'b0);
    check_for(3);
    // Integrity in idle, then escalation
    fill_mem(1'b0);
    reset_dut();
    run_init(1'b1);
    check_same_cycle_acks(1'b0);
    escalate_en_i = 1;
    @(negedge clk_i);
    if (!fsm_err_o) report("fsm_err_o", 1, DataW'(fsm_err_o));
    step();
    escalate_en_i = 0;
    @(negedge clk_i);
    if (fsm_err_o) report("fsm_err_o", 0, DataW'(fsm_err_o));
    step();
    escal = 1;
    check_for(3);

    $display("Tests done with %0d errors", err_cnt);
    if (err_cnt == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// File: filelist.f
+incdir+rtl
rtl/otp_macro_pkg.sv
rtl/otp_part_pkg.sv
rtl/otp_part_fsm.sv
rtl/otp_part_cnt.sv
rtl/otp_part_buf_regs.sv
rtl/otp_part_buf.sv
sim/otp_part_assert.sv
sim/tb_otp_part.sv

// File: run.sh
#!/bin/sh
# Build and run the OTP partition testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
  --top-module tb_otp_part -f filelist.f -o sim_otp_part

./obj_dir/sim_otp_part > sim.log 2>&1 || true
cat sim.log

if grep -q '^\*\*\* PASSED \*\*\*$' sim.log; then
  exit 0
fi
exit 1
